//--- fpgaIp.f
src/fpgaIpPkg.sv
src/timeoutCounter.sv
src/busTimeoutFsm.sv
src/wbAperture.sv
src/fpgaRegs.sv
src/fpgaRam.sv
src/fpgaIp.sv
sim/fpgaIpTb.sv

//--- sim/fpgaIpTb.sv
// Directed testbench for the slave fabric
// Inputs change on the falling edge, outputs are sampled on the falling edge
// Latency counts rising edges from the one that first samples stb to ack
// Expected RAM contents kept in a local model of written words only
`timescale 1ns/1ns
`default_nettype none

module fpgaIpTb;

    localparam int CLK_PERIOD     = 40;
    localparam int RAM_ADDR_WIDTH = 9;
    localparam int TIMEOUT_CYCLES = 7;
    localparam int MAPPED_LAT     = 1;
    localparam int UNMAPPED_LAT   = TIMEOUT_CYCLES + 1;
    localparam int NUM_RAM_WORDS  = 8;
    localparam int NUM_TRANSFERS  = 40;    // Slightly above the real count
    localparam int WATCHDOG_NS    = (NUM_TRANSFERS * (TIMEOUT_CYCLES + 4) + 20) * CLK_PERIOD;
    localparam int KNOWN_IDX      = 3;     // RAM word for the partial write
    // Window 5, same low bits as GPIO out and RAM word 3
    localparam fpgaIpPkg::busAddrT UNMAPPED_ADR = {4'd5, 13'h000C};

    logic               wbClk;
    logic               rstN;
    logic               wbCyc;
    logic               wbStb;
    logic               wbWe;
    fpgaIpPkg::busAddrT wbAdr;
    fpgaIpPkg::byteStbT wbByteStb;
    fpgaIpPkg::busDataT wbWrDat;
    fpgaIpPkg::busDataT wbRdDat;
    logic               wbAck;
    fpgaIpPkg::gpioT    gpioIn;
    fpgaIpPkg::gpioT    gpioOut;
    fpgaIpPkg::gpioT    gpioOe;

    int                 errors;
    int                 checks;
    logic [31:0]        rngState;
    fpgaIpPkg::busDataT ramModel [2**RAM_ADDR_WIDTH];
    fpgaIpPkg::gpioT    expGpioOut;    // Last value written with lane 0
    fpgaIpPkg::gpioT    expGpioOe;

    fpgaIp #(.ramAddrWidth(RAM_ADDR_WIDTH), .timeoutCycles(TIMEOUT_CYCLES)) u_dut (
        .wbClk_i(wbClk), .rstN_i(rstN), .wbCyc_i(wbCyc), .wbStb_i(wbStb),
        .wbAdr_i(wbAdr), .wbByteStb_i(wbByteStb), .wbWe_i(wbWe), .wbWrDat_i(wbWrDat),
        .wbRdDat_o(wbRdDat), .wbAck_o(wbAck),
        .gpioIn_i(gpioIn), .gpioOut_o(gpioOut), .gpioOe_o(gpioOe)
    );

    always #(CLK_PERIOD / 2) wbClk = ~wbClk;

    // --------------------
    // Helpers
    function automatic logic [31:0] nextRand();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    function automatic fpgaIpPkg::busAddrT regAddr(input fpgaIpPkg::regIdxT idx);
        return {fpgaIpPkg::REG_WINDOW, 4'b0000, idx, 2'b00};
    endfunction

    function automatic fpgaIpPkg::busAddrT ramAddr(input int idx);
        return {fpgaIpPkg::RAM_WINDOW, 13'(idx << 2)};
    endfunction

    // --------------------
    // Compare tasks
    task automatic checkData(input string name, input fpgaIpPkg::busDataT expV,
        input fpgaIpPkg::busDataT actV);
        checks++;
        if (actV !== expV)
        begin
            errors++;
            $display("FAIL %s: expected %h, actual %h", name, expV, actV);
        end
    endtask

    task automatic checkGpio(input string name, input fpgaIpPkg::gpioT expV,
        input fpgaIpPkg::gpioT actV);
        checks++;
        if (actV !== expV)
        begin
            errors++;
            $display("FAIL %s: expected %h, actual %h", name, expV, actV);
        end
    endtask

    task automatic checkLatency(input string name, input int expV, input int actV);
        checks++;
        if (actV != expV)
        begin
            errors++;
            $display("FAIL %s latency: expected %0d, actual %0d", name, expV, actV);
        end
    endtask

    task automatic checkFlag(input string name, input logic expV, input logic actV);
        checks++;
        if (actV !== expV)
        begin
            errors++;
            $display("FAIL %s: expected %b, actual %b", name, expV, actV);
        end
    endtask

    // --------------------
    // Bus handshake
    task automatic runCycle(input logic we, input fpgaIpPkg::busAddrT adr,
        input fpgaIpPkg::byteStbT stb, input fpgaIpPkg::busDataT dat,
        output fpgaIpPkg::busDataT rdDat, output int edges);
        @(negedge wbClk);              // One idle cycle between transfers
        wbCyc = 1'b1;
        wbStb = 1'b1;
        wbWe = we;
        wbAdr = adr;
        wbByteStb = stb;
        wbWrDat = dat;
        edges = 0;
        do
        begin
            @(posedge wbClk);
            edges++;
            @(negedge wbClk);
        end while (!wbAck);            // Watchdog covers a missing ack
        rdDat = wbRdDat;
        wbCyc = 1'b0;                  // Drop right after ack
        wbStb = 1'b0;
        wbWe = 1'b0;
    endtask

    task automatic busWrite(input string name, input fpgaIpPkg::busAddrT adr,
        input fpgaIpPkg::byteStbT stb, input fpgaIpPkg::busDataT dat, input int expLat);
        fpgaIpPkg::busDataT unused;
        int edges;
        runCycle(1'b1, adr, stb, dat, unused, edges);
        checkLatency(name, expLat, edges);
    endtask

    task automatic busRead(input string name, input fpgaIpPkg::busAddrT adr,
        input fpgaIpPkg::busDataT expDat, input int expLat);
        fpgaIpPkg::busDataT rdDat;
        int edges;
        runCycle(1'b0, adr, 4'hF, '0, rdDat, edges);
        checkLatency(name, expLat, edges);
        checkData(name, expDat, rdDat);
    endtask

    // --------------------
    // Tests
    task automatic testResetId();
        checkFlag("reset ack", 1'b0, wbAck);
        checkGpio("reset gpioOut", 8'h00, gpioOut);
        checkGpio("reset gpioOe", 8'h00, gpioOe);
        busRead("id reg", regAddr(fpgaIpPkg::ID_REG_IDX), fpgaIpPkg::DEVICE_ID, MAPPED_LAT);
        busRead("rev reg", regAddr(fpgaIpPkg::REV_REG_IDX), fpgaIpPkg::REV_LEVEL, MAPPED_LAT);
        busRead("undefined reg 5", regAddr(7'd5), fpgaIpPkg::DEF_REG_VALUE, MAPPED_LAT);
        busRead("undefined reg 127", regAddr(7'd127), fpgaIpPkg::DEF_REG_VALUE, MAPPED_LAT);
    endtask

    task automatic testGpio();
        // Upper bytes set, only the low byte may stick
        busWrite("gpio out write", regAddr(fpgaIpPkg::GPIO_OUT_IDX), 4'b0001,
            32'hFFFF_FF5A, MAPPED_LAT);
        expGpioOut = 8'h5A;
        busWrite("gpio oe write", regAddr(fpgaIpPkg::GPIO_OE_IDX), 4'b0001,
            32'h0000_00C3, MAPPED_LAT);
        expGpioOe = 8'hC3;
        checkGpio("gpioOut pins", expGpioOut, gpioOut);
        checkGpio("gpioOe pins", expGpioOe, gpioOe);
        busRead("gpio out readback", regAddr(fpgaIpPkg::GPIO_OUT_IDX), 32'h0000_005A,
            MAPPED_LAT);
        busRead("gpio oe readback", regAddr(fpgaIpPkg::GPIO_OE_IDX), 32'h0000_00C3,
            MAPPED_LAT);
        // Lane 0 off, registers keep their value
        busWrite("gpio out lane 0 off", regAddr(fpgaIpPkg::GPIO_OUT_IDX), 4'b1110,
            32'h0000_00A5, MAPPED_LAT);
        busWrite("gpio oe lane 0 off", regAddr(fpgaIpPkg::GPIO_OE_IDX), 4'b1110,
            32'h0000_003C, MAPPED_LAT);
        checkGpio("gpioOut pins lane 0 off", expGpioOut, gpioOut);
        checkGpio("gpioOe pins lane 0 off", expGpioOe, gpioOe);
        busRead("gpio out after lane 0 off", regAddr(fpgaIpPkg::GPIO_OUT_IDX),
            32'h0000_005A, MAPPED_LAT);
        busRead("gpio oe after lane 0 off", regAddr(fpgaIpPkg::GPIO_OE_IDX),
            32'h0000_00C3, MAPPED_LAT);
        gpioIn = 8'h96;                // Still on the falling edge here
        busRead("gpio in", regAddr(fpgaIpPkg::GPIO_IN_IDX), 32'h0000_0096, MAPPED_LAT);
    endtask

    task automatic testRam();
        int idx [NUM_RAM_WORDS];
        fpgaIpPkg::busDataT dat;
        for (int i = 0; i < NUM_RAM_WORDS; i++)
        begin
            idx[i] = int'(nextRand() % (2**RAM_ADDR_WIDTH));
            dat = nextRand();
            busWrite("ram write", ramAddr(idx[i]), 4'hF, dat, MAPPED_LAT);
            ramModel[idx[i]] = dat;     // Repeated index keeps the last word
        end
        for (int i = 0; i < NUM_RAM_WORDS; i++)
            busRead("ram readback", ramAddr(idx[i]), ramModel[idx[i]], MAPPED_LAT);
        // Partial write over a known word
        busWrite("ram known word", ramAddr(KNOWN_IDX), 4'hF, 32'h1122_3344, MAPPED_LAT);
        ramModel[KNOWN_IDX] = 32'h1122_3344;
        busWrite("ram partial write", ramAddr(KNOWN_IDX), 4'b0101, 32'hAABB_CCDD, MAPPED_LAT);
        ramModel[KNOWN_IDX] = 32'h11BB_33DD;    // Lanes 0 and 2 from the write
        busRead("ram partial readback", ramAddr(KNOWN_IDX), ramModel[KNOWN_IDX], MAPPED_LAT);
    endtask

    task automatic testUnmapped();
        busRead("unmapped read", UNMAPPED_ADR, fpgaIpPkg::DEFAULT_READ_VALUE, UNMAPPED_LAT);
        busWrite("unmapped write", UNMAPPED_ADR, 4'hF, 32'hFFFF_FFFF, UNMAPPED_LAT);
        // Nothing aliased into the mapped windows
        busRead("ram after unmapped", ramAddr(KNOWN_IDX), ramModel[KNOWN_IDX], MAPPED_LAT);
        busRead("gpio out after unmapped", regAddr(fpgaIpPkg::GPIO_OUT_IDX),
            fpgaIpPkg::busDataT'(expGpioOut), MAPPED_LAT);
        busRead("gpio oe after unmapped", regAddr(fpgaIpPkg::GPIO_OE_IDX),
            fpgaIpPkg::busDataT'(expGpioOe), MAPPED_LAT);
        checkGpio("gpioOut pins after unmapped", expGpioOut, gpioOut);
        checkGpio("gpioOe pins after unmapped", expGpioOe, gpioOe);
    endtask

    // --------------------
    // Watchdog
    initial
    begin
        #(WATCHDOG_NS);
        $display("Watchdog expired, the run hung waiting for a bus ack");
        $display("Errors found");
        $finish;
    end

    initial
    begin
        wbClk = 1'b0;
        rstN = 1'b0;
        wbCyc = 1'b0;
        wbStb = 1'b0;
        wbWe = 1'b0;
        wbAdr = '0;
        wbByteStb = '0;
        wbWrDat = '0;
        gpioIn = '0;
        errors = 0;
        checks = 0;
        rngState = 32'h2529318f;
        expGpioOut = 8'h00;
        expGpioOe = 8'h00;
        repeat (3) @(posedge wbClk);   // Reset held 3 cycles
        @(negedge wbClk);
        rstN = 1'b1;
        testResetId();
        testGpio();
        testRam();
        testUnmapped();
        $display("Checks run: %0d, mismatches: %0d", checks, errors);
        if (errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

//--- src/busTimeoutFsm.sv
// Bus timeout for cycles no slave answers
// Starts on the first edge with busy high and no ack, drops out on any ack
// Expiry gives a one-cycle ack timeoutCycles+1 edges after stb is sampled
`timescale 1ns/1ns
`default_nettype none

module busTimeoutFsm #(
    parameter int timeoutCycles = 7
) (
    input  wire  wbClk_i,
    input  wire  rstN_i,
    input  wire  busy_i,               // cyc and stb
    input  wire  ack_i,                // Combined host ack
    output logic timeoutAck_o
);

    fpgaIpPkg::timeoutStateT state;
    logic                    start;
    logic                    expired;
    logic                    ackQ;

    assign start = (state == fpgaIpPkg::TO_IDLE) & busy_i & ~ack_i;

    // Counter runs from the start edge on
    timeoutCounter #(.timeoutCycles(timeoutCycles)) u_counter (
        .wbClk_i   (wbClk_i),
        .rstN_i    (rstN_i),
        .clear_i   (start),
        .enable_i  (start | (state == fpgaIpPkg::TO_COUNT)),
        .expired_o (expired)
    );

    // --------------------
    // State machine
    always_ff @(posedge wbClk_i)
    begin
        if (!rstN_i)
        begin
            state <= fpgaIpPkg::TO_IDLE;
            ackQ  <= 1'b0;
        end
        else
        begin
            ackQ <= 1'b0;              // Default no ack
            case (state)
                fpgaIpPkg::TO_IDLE:
                begin
                    if (start)
                        state <= fpgaIpPkg::TO_COUNT;
                end
                fpgaIpPkg::TO_COUNT:
                begin
                    if (ack_i || !busy_i)
                        state <= fpgaIpPkg::TO_IDLE;  // Slave answered or host gave up
                    else if (expired)
                    begin
                        state <= fpgaIpPkg::TO_IDLE;
                        ackQ  <= 1'b1;
                    end
                end
                default: state <= fpgaIpPkg::TO_IDLE;
            endcase
        end
    end

    assign timeoutAck_o = ackQ;

endmodule

`default_nettype wire

//--- src/fpgaIp.sv
// Top of the slave fabric, one clock domain on wbClk_i
// Host holds cyc/stb and request until it samples ack, ack is one cycle
// Mapped windows ack one edge after stb, unmapped after timeoutCycles+1
// GPIO is split into in, out and enable, pad buffers live outside
`timescale 1ns/1ns
`default_nettype none

module fpgaIp #(
    parameter int ramAddrWidth  = 9,   // RAM depth 2**n words, 11 max
    parameter int timeoutCycles = 7    // Unmapped access wait
) (
    input  wire                      wbClk_i,
    input  wire                      rstN_i,
    // Host bus
    input  wire                      wbCyc_i,
    input  wire                      wbStb_i,
    input  wire fpgaIpPkg::busAddrT  wbAdr_i,
    input  wire fpgaIpPkg::byteStbT  wbByteStb_i,
    input  wire                      wbWe_i,
    input  wire fpgaIpPkg::busDataT  wbWrDat_i,
    output fpgaIpPkg::busDataT       wbRdDat_o,
    output logic                     wbAck_o,
    // GPIO
    input  wire fpgaIpPkg::gpioT     gpioIn_i,
    output fpgaIpPkg::gpioT          gpioOut_o,
    output fpgaIpPkg::gpioT          gpioOe_o
);

    fpgaIpPkg::wbReqT    wbReq;        // Request seen by all slaves
    fpgaIpPkg::slaveSelT sel;
    fpgaIpPkg::wbRspT    regsRsp;
    fpgaIpPkg::wbRspT    ramRsp;
    logic                busy;         // Host cycle in flight
    logic                timeoutAck;

    assign wbReq = '{adr: wbAdr_i, byteStb: wbByteStb_i, we: wbWe_i, wrDat: wbWrDat_i};

    // --------------------
    // Decode and read mux
    wbAperture u_aperture (
        .wbCyc_i      (wbCyc_i),
        .wbStb_i      (wbStb_i),
        .wbReq_i      (wbReq),
        .regsRsp_i    (regsRsp),
        .ramRsp_i     (ramRsp),
        .timeoutAck_i (timeoutAck),
        .sel_o        (sel),
        .busy_o       (busy),
        .wbRdDat_o    (wbRdDat_o),
        .wbAck_o      (wbAck_o)        // Also watched by timeout FSM
    );

    fpgaRegs u_regs (
        .wbClk_i   (wbClk_i),
        .rstN_i    (rstN_i),
        .sel_i     (sel.regs),
        .wbReq_i   (wbReq),
        .gpioIn_i  (gpioIn_i),
        .rsp_o     (regsRsp),
        .gpioOut_o (gpioOut_o),
        .gpioOe_o  (gpioOe_o)
    );

    fpgaRam #(.ramAddrWidth(ramAddrWidth)) u_ram (
        .wbClk_i (wbClk_i),
        .sel_i   (sel.ram),
        .wbReq_i (wbReq),
        .rsp_o   (ramRsp),
        .rstN_i  (rstN_i)
    );

    // Answers anything left unacked
    busTimeoutFsm #(.timeoutCycles(timeoutCycles)) u_timeout (
        .wbClk_i      (wbClk_i),
        .rstN_i       (rstN_i),
        .busy_i       (busy),
        .ack_i        (wbAck_o),
        .timeoutAck_o (timeoutAck)
    );

endmodule

`default_nettype wire

//--- src/fpgaIpPkg.sv
// Shared types and constants for the FPGA slave fabric
// 17-bit byte address, 32-bit data, 8 KB windows on bits 16 to 13
// Only windows 0 (registers) and 1 (RAM) are mapped
`default_nettype none

package fpgaIpPkg;

    // Widths with a meaning
    typedef logic [16:0] busAddrT;     // Host byte address
    typedef logic [31:0] busDataT;     // Bus data word
    typedef logic [3:0]  byteStbT;     // One enable per byte lane
    typedef logic [7:0]  gpioT;
    typedef logic [6:0]  regIdxT;      // Word offset in register window
    typedef logic [3:0]  windowT;      // 8 KB window number

    // Address field positions
    localparam int WIN_LSB     = 13;
    localparam int WIN_MSB     = 16;
    localparam int WORD_LSB    = 2;    // Byte offset bits below this
    localparam int REG_IDX_MSB = 8;

    // --------------------
    // Bus bundles
    typedef struct packed {
        busAddrT adr;
        byteStbT byteStb;
        logic    we;
        busDataT wrDat;
    } wbReqT;                          // 54 bits

    typedef struct packed {
        busDataT rdDat;
        logic    ack;
    } wbRspT;                          // 33 bits

    typedef struct packed {
        logic regs;
        logic ram;
    } slaveSelT;

    typedef enum logic {
        TO_IDLE,
        TO_COUNT
    } timeoutStateT;

    // --------------------
    // Window map
    localparam windowT REG_WINDOW = 4'd0;
    localparam windowT RAM_WINDOW = 4'd1;

    // Register offsets
    localparam regIdxT ID_REG_IDX   = 7'd0;
    localparam regIdxT REV_REG_IDX  = 7'd1;
    localparam regIdxT GPIO_IN_IDX  = 7'd2;
    localparam regIdxT GPIO_OUT_IDX = 7'd3;
    localparam regIdxT GPIO_OE_IDX  = 7'd4;

    // Values
    localparam busDataT DEVICE_ID          = 32'h0000_A153;
    localparam busDataT REV_LEVEL          = 32'h0000_0100;
    localparam busDataT DEF_REG_VALUE      = 32'hFAB_DEF_AC;  // Undefined register
    localparam busDataT DEFAULT_READ_VALUE = 32'hBAD_FAB_AC;  // Unmapped window
    localparam gpioT    GPIO_OUT_RESET     = 8'h00;
    localparam gpioT    GPIO_OE_RESET      = 8'h00;          // All pins inputs

endpackage

`default_nettype wire

//--- src/fpgaRam.sv
// Single-port word RAM for window 1 with byte-lane writes
// Indexed by address bits ramAddrWidth+1 down to 2, ramAddrWidth 11 max
// Contents undefined after power up, reset only clears the ack
`timescale 1ns/1ns
`default_nettype none

module fpgaRam #(
    parameter int ramAddrWidth = 9
) (
    input  wire                      wbClk_i,
    input  wire                      sel_i,
    input  wire fpgaIpPkg::wbReqT    wbReq_i,
    output fpgaIpPkg::wbRspT         rsp_o,
    input  wire                      rstN_i
);

    localparam int ramDepth = 2 ** ramAddrWidth;

    fpgaIpPkg::busDataT          mem [ramDepth];
    fpgaIpPkg::busDataT          rdDatQ;
    logic [ramAddrWidth-1:0]     wordIdx;
    logic                        ackQ;
    logic                        access;

    assign wordIdx = wbReq_i.adr[ramAddrWidth+fpgaIpPkg::WORD_LSB-1:fpgaIpPkg::WORD_LSB];
    assign access  = sel_i & ~ackQ;

    // Ack pulse
    always_ff @(posedge wbClk_i)
    begin
        if (!rstN_i)
            ackQ <= 1'b0;
        else
            ackQ <= access;
    end

    // --------------------
    // Array and read port
    always_ff @(posedge wbClk_i)
    begin
        if (access)
        begin
            rdDatQ <= mem[wordIdx];    // Old word on a write
            if (wbReq_i.we)
            begin
                for (int lane = 0; lane < 4; lane++)
                begin
                    if (wbReq_i.byteStb[lane])
                        mem[wordIdx][8*lane +: 8] <= wbReq_i.wrDat[8*lane +: 8];
                end
            end
        end
    end

    assign rsp_o = '{rdDat: rdDatQ, ack: ackQ};

endmodule

`default_nettype wire

//--- src/fpgaRegs.sv
// Register window, word offsets from address bits 8 to 2
// GPIO out and enable take byte lane 0 only, other writes are dropped
// Ack and read data registered one edge after select is sampled
// Undefined offsets read back as DEF_REG_VALUE
`timescale 1ns/1ns
`default_nettype none

module fpgaRegs (
    input  wire                      wbClk_i,
    input  wire                      rstN_i,
    input  wire                      sel_i,
    input  wire fpgaIpPkg::wbReqT    wbReq_i,
    input  wire fpgaIpPkg::gpioT     gpioIn_i,
    output fpgaIpPkg::wbRspT         rsp_o,
    output fpgaIpPkg::gpioT          gpioOut_o,
    output fpgaIpPkg::gpioT          gpioOe_o
);

    fpgaIpPkg::regIdxT   regIdx;
    fpgaIpPkg::busDataT  rdMux;        // Next read data
    fpgaIpPkg::busDataT  rdDatQ;
    fpgaIpPkg::gpioT     gpioOutQ;
    fpgaIpPkg::gpioT     gpioOeQ;
    logic                ackQ;
    logic                access;       // First cycle of a select
    logic                wrLane0;

    assign regIdx  = wbReq_i.adr[fpgaIpPkg::REG_IDX_MSB:fpgaIpPkg::WORD_LSB];
    assign access  = sel_i & ~ackQ;    // Own ack blocks a second one
    assign wrLane0 = access & wbReq_i.we & wbReq_i.byteStb[0];

    // --------------------
    // Read decode
    always_comb
    begin
        case (regIdx)
            fpgaIpPkg::ID_REG_IDX:   rdMux = fpgaIpPkg::DEVICE_ID;
            fpgaIpPkg::REV_REG_IDX:  rdMux = fpgaIpPkg::REV_LEVEL;
            fpgaIpPkg::GPIO_IN_IDX:  rdMux = fpgaIpPkg::busDataT'(gpioIn_i);  // Zero ext
            fpgaIpPkg::GPIO_OUT_IDX: rdMux = fpgaIpPkg::busDataT'(gpioOutQ);
            fpgaIpPkg::GPIO_OE_IDX:  rdMux = fpgaIpPkg::busDataT'(gpioOeQ);
            default:                 rdMux = fpgaIpPkg::DEF_REG_VALUE;
        endcase
    end

    // --------------------
    // Control and GPIO state
    always_ff @(posedge wbClk_i)
    begin
        if (!rstN_i)
        begin
            ackQ     <= 1'b0;
            gpioOutQ <= fpgaIpPkg::GPIO_OUT_RESET;
            gpioOeQ  <= fpgaIpPkg::GPIO_OE_RESET;
        end
        else
        begin
            ackQ <= access;            // Single-cycle pulse
            if (wrLane0 && regIdx == fpgaIpPkg::GPIO_OUT_IDX)
                gpioOutQ <= wbReq_i.wrDat[7:0];
            if (wrLane0 && regIdx == fpgaIpPkg::GPIO_OE_IDX)
                gpioOeQ <= wbReq_i.wrDat[7:0];
        end
    end

    // Read data captured with the ack
    always_ff @(posedge wbClk_i)
    begin
        if (access)
            rdDatQ <= rdMux;
    end

    assign rsp_o     = '{rdDat: rdDatQ, ack: ackQ};
    assign gpioOut_o = gpioOutQ;
    assign gpioOe_o  = gpioOeQ;

endmodule

`default_nettype wire

//--- src/timeoutCounter.sv
// Saturating cycle counter for the bus timeout
// A clear restarts the count, counting that cycle if enabled
`timescale 1ns/1ns
`default_nettype none

module timeoutCounter #(
    parameter int timeoutCycles = 7
) (
    input  wire  wbClk_i,
    input  wire  rstN_i,
    input  wire  clear_i,
    input  wire  enable_i,
    output logic expired_o
);

    localparam int cntWidth = $clog2(timeoutCycles + 1);

    logic [cntWidth-1:0] count;

    always_ff @(posedge wbClk_i)
    begin
        if (!rstN_i)
            count <= '0;
        else if (clear_i)
            count <= cntWidth'(enable_i);  // 1 when the clear cycle counts
        else if (enable_i && !expired_o)
            count <= count + 1'b1;         // Holds at the limit
    end

    assign expired_o = (count == cntWidth'(timeoutCycles));

endmodule

`default_nettype wire

//--- src/wbAperture.sv
// Window decode for the host bus, purely combinational
// Window taken from address bits 16 to 13 while the cycle is live
// Read data follows the address window even outside a bus cycle
`timescale 1ns/1ns
`default_nettype none

module wbAperture (
    input  wire                      wbCyc_i,
    input  wire                      wbStb_i,
    input  wire fpgaIpPkg::wbReqT    wbReq_i,
    input  wire fpgaIpPkg::wbRspT    regsRsp_i,
    input  wire fpgaIpPkg::wbRspT    ramRsp_i,
    input  wire                      timeoutAck_i,
    output fpgaIpPkg::slaveSelT      sel_o,
    output logic                     busy_o,
    output fpgaIpPkg::busDataT       wbRdDat_o,
    output logic                     wbAck_o
);

    fpgaIpPkg::windowT window;

    assign window = wbReq_i.adr[fpgaIpPkg::WIN_MSB:fpgaIpPkg::WIN_LSB];

    // Transfer in progress
    assign busy_o = wbCyc_i & wbStb_i;

    // --------------------
    // Per-slave selects
    always_comb
    begin
        sel_o      = '0;
        sel_o.regs = busy_o & (window == fpgaIpPkg::REG_WINDOW);
        sel_o.ram  = busy_o & (window == fpgaIpPkg::RAM_WINDOW);
    end

    // Read data by window
    always_comb
    begin
        case (window)
            fpgaIpPkg::REG_WINDOW: wbRdDat_o = regsRsp_i.rdDat;
            fpgaIpPkg::RAM_WINDOW: wbRdDat_o = ramRsp_i.rdDat;
            default:               wbRdDat_o = fpgaIpPkg::DEFAULT_READ_VALUE;  // Unmapped
        endcase
    end

    // One ack source at a time in practice
    assign wbAck_o = regsRsp_i.ack | ramRsp_i.ack | timeoutAck_i;

endmodule

`default_nettype wire
